// File: atom_pkg.sv
// Shared widths, bus structs, address constants and arbiter states for the Atom I/O block
package atom_pkg;

   // ======================================================================
   // Widths with a meaning
   // ======================================================================

   // 6502 address bus
   typedef logic [15:0] addr_t;

   // Data bus byte
   typedef logic [7:0] byte_t;

   // External RAM, 256 KB byte-wide
   typedef logic [17:0] ram_addr_t;

   // 8 KB video RAM
   typedef logic [12:0] vid_addr_t;

   // ======================================================================
   // Bus structs
   // ======================================================================

   // One CPU bus cycle, as held between two clock enables
   typedef struct packed {
      addr_t addr;
      byte_t wdata;
      logic  rnw;
   } cpu_bus_t;

   // Device selects for the current access
   // vid, pia, unmapped, rom_latch and ram are exclusive
   // rom and a000 only qualify the access
   typedef struct packed {
      logic vid;
      logic pia;
      logic unmapped;
      logic rom;
      logic rom_latch;
      logic a000;
      logic ram;
   } dev_sel_t;

   // Video RAM read port owner
   typedef enum logic [1:0] {
      VID_IDLE     = 2'b00,
      VID_CHECK    = 2'b01,
      VID_CPU_ADDR = 2'b10,
      VID_CPU_DATA = 2'b11
   } vid_rd_state_t;

   // ======================================================================
   // Fixed addresses
   // ======================================================================

   // Zero page byte whose bit 5 is the lock flag
   localparam addr_t LOCK_ADDR = 16'h00e7;

   // Paged ROM bank latch
   localparam addr_t ROM_LATCH_ADDR = 16'hbfff;

endpackage

// File: atom_clken.sv
// CPU clock-enable divider, one clk64 pulse every 2^CLK_DIV_BITS cycles
`timescale 1ns/1ps

module atom_clken #(
   parameter int CLK_DIV_BITS = 7
) (
   input  logic clk64,
   input  logic reset,
   output logic cpu_clken
);

   // Free-running divider
   logic [CLK_DIV_BITS-1:0] div_cnt;

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         div_cnt   <= '0;
         cpu_clken <= 1'b0;
      end
      else
      begin
         div_cnt   <= div_cnt + 1'b1;
         // Registered divider-zero strobe
         cpu_clken <= (div_cnt == '0);
      end
   end

   // Enable is a single-cycle strobe
   assert property (@(posedge clk64) disable iff (reset)
      cpu_clken |=> !cpu_clken)
      else $error("cpu_clken high on two consecutive cycles");

endmodule

// File: atom_bus_capture.sv
// CPU bus input register, sampled on each clock enable, plus the lock flag snoop
`timescale 1ns/1ps

module atom_bus_capture (
   input  logic             clk64,
   input  logic             reset,
   input  logic             cpu_clken,
   input  atom_pkg::addr_t  cpu_addr,
   input  atom_pkg::byte_t  cpu_wdata,
   input  logic             cpu_rnw,
   output atom_pkg::cpu_bus_t bus,
   output logic             lock
);

   import atom_pkg::*;

   // ======================================================================
   // Bus register
   // ======================================================================

   // Holds the access for a whole enable period
   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         // Idle as a read of 0000
         bus.addr  <= '0;
         bus.wdata <= '0;
         bus.rnw   <= 1'b1;
      end
      else if (cpu_clken)
      begin
         bus.addr  <= cpu_addr;
         bus.wdata <= cpu_wdata;
         bus.rnw   <= cpu_rnw;
      end
   end

   // ======================================================================
   // Lock flag
   // ======================================================================

   // Bit 5 of #E7, taken when the write access ends
   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (cpu_clken && !bus.rnw && (bus.addr == LOCK_ADDR))
         lock <= bus.wdata[5];
   end

endmodule

// File: atom_mem_map.sv
// Atom address decoder, ROM bank latch, external RAM mapping and CPU read mux
`timescale 1ns/1ps

module atom_mem_map (
   input  logic                clk64,
   input  logic                reset,
   input  logic                cpu_clken,
   input  atom_pkg::cpu_bus_t  bus,
   output atom_pkg::dev_sel_t  sel,
   output atom_pkg::ram_addr_t ram_addr,
   output logic                ram_we,
   output logic                ram_oe,
   input  atom_pkg::byte_t     ram_rdata,
   input  atom_pkg::byte_t     pia_rdata,
   input  atom_pkg::byte_t     vid_rdata,
   output atom_pkg::byte_t     cpu_din
);

   import atom_pkg::*;

   // Bank latch at BFFF
   byte_t rom_latch;
   // Set once the first access has been captured
   logic  access_valid;

   // ======================================================================
   // Address decode
   // ======================================================================

   always_comb
   begin
      // Video RAM 8000-97FF
      sel.vid       = (bus.addr[15:12] == 4'h8) || (bus.addr[15:11] == 5'b10010);
      // 8255 at B000-B00F
      sel.pia       = (bus.addr[15:4] == 12'hb00);
      // Removed device windows
      sel.unmapped  = (bus.addr[15:4] == 12'hb40) || (bus.addr[15:4] == 12'hb80) ||
                      (bus.addr[15:4] == 12'hbc0) || (bus.addr[15:8] == 8'hbd);
      sel.rom_latch = (bus.addr == ROM_LATCH_ADDR);
      sel.a000      = (bus.addr[15:12] == 4'ha);
      // Upper 16 KB always ROM, A000 bank ROM unless bank 7 is paged in
      sel.rom       = (bus.addr[15:14] == 2'b11) ||
                      (sel.a000 && (rom_latch[2:0] != 3'b111));
      // Everything else lands in external RAM
      sel.ram       = !(sel.vid || sel.pia || sel.unmapped || sel.rom_latch);
   end

   // ======================================================================
   // External RAM port
   // ======================================================================

   // A000 window pages through 4 KB banks at 0x10000 upwards
   assign ram_addr = sel.a000 ? {3'b010, rom_latch[2:0], bus.addr[11:0]} :
                                {2'b00, bus.addr};

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
         access_valid <= 1'b0;
      else if (cpu_clken)
         access_valid <= 1'b1;
   end

   // Strobes drop on the enable cycle while the bus changes over
   assign ram_we = access_valid && !cpu_clken && !bus.rnw && !sel.rom;
   assign ram_oe = access_valid && !cpu_clken && bus.rnw;

   // ROM bank latch
   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
         rom_latch <= '0;
      else if (cpu_clken && sel.rom_latch && !bus.rnw)
         rom_latch <= bus.wdata;
   end

   // CPU read data
   always_comb
   begin
      if (sel.vid)
         cpu_din = vid_rdata;
      else if (sel.pia)
         cpu_din = pia_rdata;
      else if (sel.unmapped)
         cpu_din = '0;
      else if (sel.rom_latch)
         cpu_din = rom_latch;
      else
         cpu_din = ram_rdata;
   end

   assert property (@(posedge clk64) disable iff (reset)
      $onehot({sel.vid, sel.pia, sel.unmapped, sel.rom_latch, sel.ram}))
      else $error("Device selects not one-hot");

endmodule

// File: atom_pia.sv
// 8255 PIA model with fixed port directions, keyboard scan and video mode bits
`timescale 1ns/1ps

module atom_pia (
   input  logic               clk64,
   input  logic               reset,
   input  logic               cpu_clken,
   input  atom_pkg::cpu_bus_t bus,
   input  atom_pkg::dev_sel_t sel,
   input  logic [5:0]         keyout,
   input  logic               shift_n,
   input  logic               ctrl_n,
   input  logic               rept_n,
   input  logic               cas_in,
   input  logic               fs_n,
   input  logic               cas_tone,
   output atom_pkg::byte_t    rdata,
   output logic [3:0]         kbd_row,
   output logic               an_g,
   output logic [2:0]         gm,
   output logic               css,
   output logic [3:0]         pc_low
);

   import atom_pkg::*;

   // Port A is all output
   byte_t      port_a;
   // Port C low nibble is output, high nibble input
   logic [3:0] port_c;

   // ======================================================================
   // Register writes
   // ======================================================================

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         port_a <= '0;
         port_c <= '0;
      end
      else if (cpu_clken && sel.pia && !bus.rnw)
      begin
         case (bus.addr[1:0])
            2'b00: port_a <= bus.wdata;
            2'b10: port_c <= bus.wdata[3:0];
            // Control word with bit 7 clear is a port C bit set/reset
            2'b11:
            begin
               if (!bus.wdata[7])
                  port_c[bus.wdata[2:1]] <= bus.wdata[0];
            end
            default: ;
         endcase
      end
   end

   // ======================================================================
   // Register reads
   // ======================================================================

   always_comb
   begin
      case (bus.addr[1:0])
         2'b00: rdata = port_a;
         // Modifier keys above the six return lines
         2'b01: rdata = {shift_n, ctrl_n, keyout};
         2'b10: rdata = {fs_n, rept_n, cas_in, cas_tone, port_c};
         default: rdata = '0;
      endcase
   end

   // Keyboard row select and 6847 mode pins
   assign kbd_row = port_a[3:0];
   assign an_g    = port_a[4];
   assign gm      = port_a[7:5];
   // Colour set select
   assign css     = port_c[3];
   // Cassette and sound controls
   assign pc_low  = port_c;

endmodule

// File: atom_vid_ram.sv
// 8 KB video RAM whose single read port is shared by the CPU and the video generator
`timescale 1ns/1ps

module atom_vid_ram (
   input  logic                clk64,
   input  logic                reset,
   input  logic                cpu_clken,
   input  atom_pkg::cpu_bus_t  bus,
   input  atom_pkg::dev_sel_t  sel,
   input  atom_pkg::vid_addr_t vdg_addr,
   output atom_pkg::byte_t     vdg_data,
   output atom_pkg::byte_t     cpu_rdata
);

   import atom_pkg::*;

   byte_t         mem [0:8191];
   vid_rd_state_t rd_state;
   vid_addr_t     rd_addr;
   // Raw read port output one cycle behind rd_addr
   byte_t         ram_data;

   // ======================================================================
   // Memory array
   // ======================================================================

   // CPU write held for the whole access
   always_ff @(posedge clk64)
   begin
      if (sel.vid && !bus.rnw)
         mem[bus.addr[12:0]] <= bus.wdata;
   end

   // CPU owns the read port only in VID_CPU_ADDR
   assign rd_addr = (rd_state == VID_CPU_ADDR) ? bus.addr[12:0] : vdg_addr;

   always_ff @(posedge clk64)
   begin
      ram_data <= mem[rd_addr];
   end

   // ======================================================================
   // Read arbiter
   // ======================================================================

   // CPU gets priority and video slips by one slot at most
   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
         rd_state <= VID_IDLE;
      else
      begin
         case (rd_state)
            VID_IDLE:
            begin
               if (cpu_clken)
                  rd_state <= VID_CHECK;
            end
            // New access is on the bus now
            VID_CHECK:
            begin
               if (sel.vid && bus.rnw)
                  rd_state <= VID_CPU_ADDR;
               else
                  rd_state <= VID_IDLE;
            end
            VID_CPU_ADDR: rd_state <= VID_CPU_DATA;
            default:      rd_state <= VID_IDLE;
         endcase
      end
   end

   // Holding registers for each reader
   always_ff @(posedge clk64)
   begin
      if (rd_state == VID_CPU_DATA)
         cpu_rdata <= ram_data;
      else
         vdg_data <= ram_data;
   end

   // New access must find the arbiter idle or its read slot is lost
   assert property (@(posedge clk64) disable iff (reset)
      cpu_clken |-> (rd_state == VID_IDLE))
      else $error("Clock enable arrived while the arbiter was busy");

endmodule

// File: atom_cassette.sv
// Cassette tone divider and the output gate driven by port C
`timescale 1ns/1ps

module atom_cassette #(
   parameter int CAS_DIV = 208
) (
   input  logic       clk64,
   input  logic       reset,
   input  logic       cpu_clken,
   input  logic [3:0] pc_low,
   output logic       cas_tone,
   output logic       cas_out
);

   localparam int CNT_W = $clog2(CAS_DIV);

   // Enables counted within one tone half-period
   logic [CNT_W-1:0] cas_cnt;

   always_ff @(posedge clk64 or posedge reset)
   begin
      if (reset)
      begin
         cas_cnt  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_cnt == CNT_W'(CAS_DIV - 1))
         begin
            cas_cnt  <= '0;
            cas_tone <= !cas_tone;
         end
         else
            cas_cnt <= cas_cnt + 1'b1;
      end
   end

   // Two NANDs and an inverter on the real board
   // PC0 low forces the line high, PC1 lets the tone through
   assign cas_out = !pc_low[0] || (pc_low[1] && !cas_tone);

endmodule

// File: atom_io.sv
// Atom I/O and memory glue top level, attached to an external 6502 and external RAM
`timescale 1ns/1ps

module atom_io #(
   parameter int CLK_DIV_BITS = 7,
   parameter int CAS_DIV      = 208
) (
   input  logic                clk64,
   input  logic                reset,
   // CPU bus
   input  atom_pkg::addr_t     cpu_addr,
   input  atom_pkg::byte_t     cpu_wdata,
   input  logic                cpu_rnw,
   output atom_pkg::byte_t     cpu_din,
   output logic                cpu_clken,
   // External RAM
   output atom_pkg::ram_addr_t ram_addr,
   output logic                ram_we,
   output logic                ram_oe,
   input  atom_pkg::byte_t     ram_rdata,
   // Keyboard and cassette inputs
   input  logic [5:0]          keyout,
   input  logic                shift_n,
   input  logic                ctrl_n,
   input  logic                rept_n,
   input  logic                cas_in,
   input  logic                fs_n,
   // Video generator port
   input  atom_pkg::vid_addr_t vdg_addr,
   output atom_pkg::byte_t     vdg_data,
   output logic                an_g,
   output logic [2:0]          gm,
   output logic                css,
   // Misc outputs
   output logic [3:0]          kbd_row,
   output logic                cas_out,
   output logic                lock
);

   import atom_pkg::*;

   cpu_bus_t   bus;
   dev_sel_t   sel;
   byte_t      pia_rdata;
   byte_t      vid_rdata;
   logic       cas_tone;
   logic [3:0] pc_low;

   atom_clken #(.CLK_DIV_BITS(CLK_DIV_BITS)) u_clken (
      .clk64(clk64), .reset(reset), .cpu_clken(cpu_clken)
   );

   atom_bus_capture u_bus (
      .clk64(clk64), .reset(reset), .cpu_clken(cpu_clken),
      .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_rnw(cpu_rnw),
      .bus(bus), .lock(lock)
   );

   atom_mem_map u_map (
      .clk64(clk64), .reset(reset), .cpu_clken(cpu_clken), .bus(bus), .sel(sel),
      .ram_addr(ram_addr), .ram_we(ram_we), .ram_oe(ram_oe), .ram_rdata(ram_rdata),
      .pia_rdata(pia_rdata), .vid_rdata(vid_rdata), .cpu_din(cpu_din)
   );

   atom_pia u_pia (
      .clk64(clk64), .reset(reset), .cpu_clken(cpu_clken), .bus(bus), .sel(sel),
      .keyout(keyout), .shift_n(shift_n), .ctrl_n(ctrl_n), .rept_n(rept_n),
      .cas_in(cas_in), .fs_n(fs_n), .cas_tone(cas_tone), .rdata(pia_rdata),
      .kbd_row(kbd_row), .an_g(an_g), .gm(gm), .css(css), .pc_low(pc_low)
   );

   atom_vid_ram u_vid (
      .clk64(clk64), .reset(reset), .cpu_clken(cpu_clken), .bus(bus), .sel(sel),
      .vdg_addr(vdg_addr), .vdg_data(vdg_data), .cpu_rdata(vid_rdata)
   );

   atom_cassette #(.CAS_DIV(CAS_DIV)) u_cas (
      .clk64(clk64), .reset(reset), .cpu_clken(cpu_clken), .pc_low(pc_low),
      .cas_tone(cas_tone), .cas_out(cas_out)
   );

endmodule

// File: tb_atom_model.svh
// Reference rules for the Atom address map, PIA ports, RAM fill and cassette gate, included by the testbench
`ifndef TB_ATOM_MODEL_SVH
`define TB_ATOM_MODEL_SVH

// Device kinds of the address map
localparam int KIND_RAM   = 0;
localparam int KIND_VID   = 1;
localparam int KIND_PIA   = 2;
localparam int KIND_ZERO  = 3;
localparam int KIND_LATCH = 4;

function automatic int addr_kind(input logic [15:0] a);
   if (a >= 16'h8000 && a <= 16'h97ff)
      return KIND_VID;
   if (a >= 16'hb000 && a <= 16'hb00f)
      return KIND_PIA;
   // Dropped SID, VIA and SPI windows
   if ((a >= 16'hb400 && a <= 16'hb40f) || (a >= 16'hb800 && a <= 16'hb80f) ||
       (a >= 16'hbc00 && a <= 16'hbc0f) || (a >= 16'hbd00 && a <= 16'hbdff))
      return KIND_ZERO;
   if (a == 16'hbfff)
      return KIND_LATCH;
   return KIND_RAM;
endfunction

function automatic logic is_rom(input logic [15:0] a, input logic [7:0] latch);
   if (a >= 16'hc000)
      return 1'b1;
   // Bank 7 is RAM in the A000 window
   return (a >= 16'ha000 && a <= 16'hafff && latch[2:0] != 3'd7);
endfunction

function automatic logic [17:0] ext_addr(input logic [15:0] a, input logic [7:0] latch);
   if (a >= 16'ha000 && a <= 16'hafff)
      return 18'h10000 | (18'(latch[2:0]) << 12) | 18'(a[11:0]);
   return {2'b00, a};
endfunction

// Port C bit set/reset by control word
function automatic logic [3:0] pc_bit_op(input logic [3:0] pc, input logic [7:0] ctrl);
   logic [3:0] r;
   r = pc;
   if (!ctrl[7])
      r[ctrl[2:1]] = ctrl[0];
   return r;
endfunction

// mods is shift_n then ctrl_n, pc_in is fs_n, rept_n, cas_in, tone
function automatic logic [7:0] pia_read(input logic [1:0] reg_sel, input logic [7:0] pa,
                                        input logic [3:0] pc, input logic [5:0] keys,
                                        input logic [1:0] mods, input logic [3:0] pc_in);
   case (reg_sel)
      2'd0: return pa;
      2'd1: return {mods, keys};
      2'd2: return {pc_in, pc};
      default: return 8'h00;
   endcase
endfunction

function automatic logic cas_gate(input logic [3:0] pc, input logic tone);
   return !pc[0] || (pc[1] && !tone);
endfunction

// Power-up contents of external RAM
function automatic logic [7:0] ram_fill(input logic [17:0] a);
   return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]} ^ 8'h5a;
endfunction

`endif

// File: tb_atom_io.sv
// Testbench that plays the 6502 and external RAM around the Atom I/O block and checks a model
`timescale 1ns/1ps

module tb_atom_io;

   import atom_pkg::*;

   localparam int TIMEOUT = 100;

   logic       clk64 = 1'b0;
   logic       reset;
   addr_t      cpu_addr;
   byte_t      cpu_wdata;
   byte_t      cpu_din;
   logic       cpu_rnw;
   logic       cpu_clken;
   ram_addr_t  ram_addr;
   logic       ram_we;
   logic       ram_oe;
   byte_t      ram_rdata;
   logic [5:0] keyout;
   logic       shift_n;
   logic       ctrl_n;
   logic       rept_n;
   logic       cas_in;
   logic       fs_n;
   vid_addr_t  vdg_addr;
   byte_t      vdg_data;
   logic       an_g;
   logic [2:0] gm;
   logic       css;
   logic [3:0] kbd_row;
   logic       cas_out;
   logic       lock;

   // ======================================================================
   // Model state
   // ======================================================================

   byte_t       ext_ram [0:262143];
   byte_t       vid_mem [0:8191];
   byte_t       m_port_a;
   logic [3:0]  m_port_c;
   byte_t       m_latch;
   logic        m_lock;
   logic        tone_model;
   int          tone_cnt;
   // Last stable sample before the next enable
   byte_t       s_din;
   ram_addr_t   s_ram_addr;
   logic        s_we_any;
   logic        s_oe;
   logic        s_tone;
   logic [31:0] rng_state = 32'hb52b;
   int          checks;
   int          errors;
   int          test_errors;

   `include "tb_atom_model.svh"

   atom_io #(.CLK_DIV_BITS(3)) DUT (.*);

   always #50 clk64 = ~clk64;

   // External RAM answers combinationally
   assign ram_rdata = ext_ram[ram_addr];

   // Tone half-period is 208 enables
   always @(negedge clk64)
   begin
      if (reset)
      begin
         tone_cnt = 0;
         tone_model = 1'b0;
      end
      else if (cpu_clken)
      begin
         tone_cnt = tone_cnt + 1;
         if (tone_cnt == 208)
         begin
            tone_cnt = 0;
            tone_model = !tone_model;
         end
      end
   end

   // ======================================================================
   // Helpers
   // ======================================================================

   function automatic logic [31:0] rand_next();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
   endtask

   // Falling edges until cpu_clken is seen high
   task automatic wait_clken(output int cycles);
      cycles = 0;
      while (!cpu_clken)
      begin
         @(negedge clk64);
         cycles++;
         if (cycles > TIMEOUT)
            timeout_fail("clock enable");
      end
   endtask

   // Samples outputs up to the cycle before the next enable
   task automatic settle_access();
      int n;
      n = 0;
      s_we_any = 1'b0;
      @(negedge clk64);
      while (!cpu_clken)
      begin
         s_din = cpu_din;
         s_ram_addr = ram_addr;
         s_we_any = s_we_any | ram_we;
         s_oe = ram_oe;
         s_tone = tone_model;
         n++;
         if (n > TIMEOUT)
            timeout_fail("end of access");
         @(negedge clk64);
      end
   endtask

   function automatic byte_t expected_din(input addr_t a);
      case (addr_kind(a))
         KIND_VID: return vid_mem[a[12:0]];
         KIND_PIA: return pia_read(a[1:0], m_port_a, m_port_c, keyout, {shift_n, ctrl_n},
                                   {fs_n, rept_n, cas_in, s_tone});
         KIND_ZERO: return 8'h00;
         KIND_LATCH: return m_latch;
         default: return ext_ram[ext_addr(a, m_latch)];
      endcase
   endfunction

   // Effects that land on the enable ending the access
   task automatic commit_write(input addr_t a, input byte_t d, input logic rnw);
      if (!rnw)
      begin
         if (!is_rom(a, m_latch))
            ext_ram[ext_addr(a, m_latch)] = d;
         case (addr_kind(a))
            KIND_VID: vid_mem[a[12:0]] = d;
            KIND_LATCH: m_latch = d;
            KIND_PIA:
            begin
               if (a[1:0] == 2'd0)
                  m_port_a = d;
               else if (a[1:0] == 2'd2)
                  m_port_c = d[3:0];
               else if (a[1:0] == 2'd3)
                  m_port_c = pc_bit_op(m_port_c, d);
            end
            default: ;
         endcase
         if (a == LOCK_ADDR)
            m_lock = d[5];
      end
   endtask

   // One CPU cycle with fresh keyboard and cassette inputs
   task automatic run_access(input string name, input addr_t a, input byte_t d,
                             input logic rnw);
      logic [31:0] r;
      int          n;
      wait_clken(n);
      @(posedge clk64);
      #1;
      r = rand_next();
      cpu_addr = a;
      cpu_wdata = d;
      cpu_rnw = rnw;
      keyout = r[5:0];
      {shift_n, ctrl_n, rept_n, cas_in, fs_n} = r[10:6];
      wait_clken(n);
      // Capture edge
      @(posedge clk64);
      settle_access();
      check_value({name, " ram_addr"}, ext_addr(a, m_latch), s_ram_addr);
      check_value({name, " ram_we"}, !rnw && !is_rom(a, m_latch), s_we_any);
      check_value({name, " ram_oe"}, rnw, s_oe);
      check_value({name, " lock"}, m_lock, lock);
      check_value({name, " port A pins"}, m_port_a, {gm, an_g, kbd_row});
      check_value({name, " css"}, m_port_c[3], css);
      if (rnw)
         check_value({name, " cpu_din"}, expected_din(a), s_din);
      commit_write(a, d, rnw);
   endtask

   task automatic end_test(input string name);
      $display("Test %s done: %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   // ======================================================================
   // Test sequence
   // ======================================================================

   initial
   begin
      logic [31:0] r;
      addr_t       a;
      int          n;
      byte_t       cas_modes [3];
      reset = 1'b1;
      cpu_addr = '0;
      cpu_wdata = '0;
      cpu_rnw = 1'b1;
      keyout = '0;
      {shift_n, ctrl_n, rept_n, cas_in, fs_n} = '1;
      vdg_addr = '0;
      m_port_a = '0;
      m_port_c = '0;
      m_latch = '0;
      m_lock = 1'b0;
      checks = 0;
      errors = 0;
      test_errors = 0;
      cas_modes = '{8'h03, 8'h01, 8'h02};
      for (int i = 0; i < 262144; i++)
         ext_ram[i] = ram_fill(18'(i));

      // Reset held for 4 rising edges
      for (int i = 0; i < 3; i++)
      begin
         @(negedge clk64);
         check_value("reset outputs", 0,
                     {cpu_clken, ram_we, ram_oe, lock, gm, an_g, kbd_row, css});
      end
      @(posedge clk64);
      #1;
      reset = 1'b0;
      @(negedge clk64);
      check_value("first enable low", 0, cpu_clken);
      @(negedge clk64);
      check_value("first enable high", 1, cpu_clken);
      for (int i = 0; i < 4; i++)
      begin
         @(negedge clk64);
         wait_clken(n);
         check_value("enable period", 8, n + 1);
      end
      end_test("reset_clken");

      // Ports A and C, port B and high C from random inputs
      for (int i = 0; i < 48; i++)
      begin
         r = rand_next();
         run_access("pia", {12'hb00, r[3:0]}, r[15:8], r[4]);
      end
      end_test("pia");

      // Random map, plus removed windows and ROM writes
      for (int i = 0; i < 80; i++)
      begin
         r = rand_next();
         a = r[15:0];
         if (addr_kind(a) == KIND_VID)
            a = a ^ 16'h4000;
         if (r[18:17] == 2'd0)
            a = (r[20:19] == 2'd3) ? {8'hbd, a[7:0]} :
                                     {4'hb, r[20:19] + 2'd1, 6'd0, a[3:0]};
         else if (r[18:17] == 2'd1)
            a = {2'b11, a[13:0]};
         run_access("map", a, r[31:24], (r[18:17] == 2'd1) ? 1'b0 : r[21]);
      end
      end_test("mem_map");

      // Even rounds page RAM bank 7 into A000
      for (int i = 0; i < 12; i++)
      begin
         r = rand_next();
         run_access("latch", ROM_LATCH_ADDR, (i % 2 == 0) ? (r[7:0] | 8'h07) : r[7:0], 1'b0);
         run_access("latch", ROM_LATCH_ADDR, 8'h00, 1'b1);
         run_access("bank", {4'ha, r[27:16]}, r[31:24], 1'b0);
         run_access("bank", {4'ha, r[27:16]}, 8'h00, 1'b1);
         run_access("lock", LOCK_ADDR, r[15:8], 1'b0);
      end
      end_test("rom_latch_lock");

      // CPU and video ports of the video RAM
      for (int i = 0; i < 20; i++)
      begin
         r = rand_next();
         a = 16'h8000 + 16'(r[15:0] % 16'h1800);
         run_access("vid", a, r[23:16], 1'b0);
         run_access("vid", a, 8'h00, 1'b1);
         @(posedge clk64);
         #1;
         vdg_addr = a[12:0];
         repeat (6) @(negedge clk64);
         check_value("vdg_data", vid_mem[a[12:0]], vdg_data);
      end
      end_test("video_ram");

      // Each window spans at least one tone toggle
      for (int k = 0; k < 3; k++)
      begin
         run_access("cassette", 16'hb002, cas_modes[k], 1'b0);
         for (int i = 0; i < 1800; i++)
         begin
            @(negedge clk64);
            if (!cpu_clken)
               check_value("cas_out", cas_gate(m_port_c, tone_model), cas_out);
         end
      end
      end_test("cassette");

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: atom_io.f
+incdir+.
atom_pkg.sv
atom_clken.sv
atom_bus_capture.sv
atom_mem_map.sv
atom_pia.sv
atom_vid_ram.sv
atom_cassette.sv
atom_io.sv
tb_atom_io.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the atom_io testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 \
   -f atom_io.f --top-module tb_atom_io -o sim_atom_io
./obj_dir/sim_atom_io | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1
